// File: source/i2c_pkg.sv
package i2c_pkg;

    localparam int unsigned BYTE_BITS = 8;

    typedef logic [BYTE_BITS-1:0] byte_t;

    // engine operations, op_start doubles as repeated start
    typedef enum logic [1:0] {
        op_start,
        op_stop,
        op_write,
        op_read
    } i2c_op_e;

    typedef struct packed {
        i2c_op_e op;
        byte_t   data;   // byte to send on op_write
        logic    last;   // op_read only, host nacks the byte
    } i2c_cmd_t;

    typedef struct packed {
        byte_t data;     // byte received on op_read
        logic  nack;     // slave acknowledge after op_write, high = nack
    } i2c_rsp_t;

endpackage

// File: source/eeprom_pkg.sv
package eeprom_pkg;

    // 24C16 style part, 2k x 8
    localparam int unsigned MEM_DEPTH = 2048;
    localparam int unsigned ADDR_BITS = $clog2(MEM_DEPTH);

    // device type code, upper nibble of the control byte
    localparam logic [3:0] DEV_CODE = 4'b1010;

    typedef logic [ADDR_BITS-1:0] eeprom_addr_t;
    typedef logic [7:0]           eeprom_data_t;

endpackage

// File: source/i2c_byte_engine.sv
`timescale 1ns/1ps

module i2c_byte_engine import i2c_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     cmd_valid,
    input  i2c_cmd_t cmd,
    output logic     done,
    output i2c_rsp_t rsp,
    output logic     scl,
    output logic     sda_low,
    input  logic     sda_in
);

    typedef enum logic [2:0] {
        s_idle,
        s_start,
        s_stop,
        s_shout,
        s_shin,
        s_ack
    } eng_state_e;

    eng_state_e state;
    logic [1:0] step;       // start/stop sub-step
    logic [2:0] bit_cnt;    // bits left after the current one
    logic       phase;      // high in the scl high half
    byte_t      sh;
    logic       last_q;
    logic       is_rd;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= s_idle;
            step    <= '0;
            bit_cnt <= '0;
            phase   <= 1'b0;
            scl     <= 1'b1;
            sda_low <= 1'b0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                s_idle: begin
                    if (cmd_valid) begin
                        scl     <= 1'b0;
                        step    <= '0;
                        bit_cnt <= 3'(BYTE_BITS - 1);
                        phase   <= 1'b0;
                        case (cmd.op)
                            op_start: begin
                                sda_low <= 1'b0;    // release while scl low
                                state   <= s_start;
                            end
                            op_stop: begin
                                sda_low <= 1'b1;
                                state   <= s_stop;
                            end
                            op_write: begin
                                sda_low <= ~cmd.data[7];    // msb first
                                state   <= s_shout;
                            end
                            default: begin
                                sda_low <= 1'b0;
                                state   <= s_shin;
                            end
                        endcase
                    end
                end

                s_start: begin
                    step <= step + 2'd1;
                    case (step)
                        2'd0: scl <= 1'b1;
                        2'd1: sda_low <= 1'b1;  // sda falls with scl high
                        default: begin
                            scl   <= 1'b0;
                            done  <= 1'b1;
                            state <= s_idle;
                        end
                    endcase
                end

                s_stop: begin
                    step <= step + 2'd1;
                    case (step)
                        2'd0: scl <= 1'b1;
                        2'd1: sda_low <= 1'b0;  // sda rises with scl high
                        default: begin
                            done  <= 1'b1;
                            state <= s_idle;
                        end
                    endcase
                end

                s_shout, s_shin: begin
                    phase <= ~phase;
                    if (!phase) begin
                        scl <= 1'b1;
                    end else begin
                        scl <= 1'b0;
                        if (bit_cnt == '0) begin
                            // slave drives the ack bit after a write, host after a read
                            sda_low <= (state == s_shin) ? ~last_q : 1'b0;
                            state   <= s_ack;
                        end else begin
                            bit_cnt <= bit_cnt - 3'd1;
                            sda_low <= (state == s_shout) ? ~sh[6] : 1'b0;
                        end
                    end
                end

                s_ack: begin
                    phase <= ~phase;
                    if (!phase) begin
                        scl  <= 1'b1;
                        done <= 1'b1;
                    end else begin
                        scl   <= 1'b0;  // leave scl low for the next command
                        state <= s_idle;
                    end
                end

                default: state <= s_idle;
            endcase
        end
    end

    // shift register and response
    always_ff @(posedge clk) begin
        if (state == s_idle && cmd_valid) begin
            sh     <= cmd.data;
            last_q <= cmd.last;
            is_rd  <= (cmd.op == op_read);
        end else if (state == s_shout && phase && bit_cnt != '0) begin
            sh <= {sh[6:0], 1'b0};
        end else if (state == s_shin && !phase) begin
            sh <= {sh[6:0], sda_in};    // sample at scl rise
        end

        if (state == s_ack && !phase) begin
            rsp.data <= sh;
            rsp.nack <= sda_in & ~is_rd;
        end
    end

endmodule

// File: source/eeprom_wr.sv
`timescale 1ns/1ps

module eeprom_wr import i2c_pkg::*, eeprom_pkg::*; (
    input  logic         clk,
    input  logic         arst_n,
    input  logic         wr,
    input  logic         rd,
    input  eeprom_addr_t addr,
    input  eeprom_data_t wdata,
    output eeprom_data_t rdata,
    output logic         ack,
    output logic         err,
    output logic         cmd_valid,
    output i2c_cmd_t     cmd,
    input  logic         done,
    input  i2c_rsp_t     rsp
);

    // each state names the engine command in flight
    typedef enum logic [3:0] {
        idle,
        write_start,
        ctrl_write,
        addr_write,
        data_write,
        read_start,
        ctrl_read,
        data_read,
        stop,
        ackn
    } main_state_e;

    main_state_e  state;
    main_state_e  state_nxt;
    logic         rd_q;
    eeprom_addr_t addr_q;
    eeprom_data_t wdata_q;
    logic         start_req;
    logic         byte_wr;
    logic         nack_hit;
    byte_t        ctrl_byte;

    assign start_req = (state == idle) && (wr || rd);

    // states whose done carries a slave acknowledge
    assign byte_wr = (state == ctrl_write) || (state == addr_write) ||
                     (state == data_write) || (state == ctrl_read);

    assign nack_hit = done && byte_wr && rsp.nack;

    // device code, block select bits, r/w
    assign ctrl_byte = {DEV_CODE, addr_q[10:8], state == ctrl_read};

    always_comb begin
        state_nxt = state;
        case (state)
            idle: begin
                if (wr || rd) begin
                    state_nxt = write_start;
                end
            end
            write_start: begin
                if (done) begin
                    state_nxt = ctrl_write;
                end
            end
            ctrl_write: begin
                if (done) begin
                    state_nxt = rsp.nack ? stop : addr_write;
                end
            end
            addr_write: begin
                if (done) begin
                    if (rsp.nack) begin
                        state_nxt = stop;
                    end else begin
                        state_nxt = rd_q ? read_start : data_write;
                    end
                end
            end
            read_start: begin
                if (done) begin
                    state_nxt = ctrl_read;
                end
            end
            ctrl_read: begin
                if (done) begin
                    state_nxt = rsp.nack ? stop : data_read;
                end
            end
            data_write, data_read: begin
                if (done) begin
                    state_nxt = stop;
                end
            end
            stop: begin
                if (done) begin
                    state_nxt = ackn;
                end
            end
            default: state_nxt = idle;  // ackn
        endcase
    end

    always_comb begin
        cmd = '{op: op_stop, data: '0, last: 1'b0};
        case (state)
            write_start, read_start: cmd.op = op_start;
            ctrl_write, ctrl_read: begin
                cmd.op   = op_write;
                cmd.data = ctrl_byte;
            end
            addr_write: begin
                cmd.op   = op_write;
                cmd.data = addr_q[7:0];
            end
            data_write: begin
                cmd.op   = op_write;
                cmd.data = wdata_q;
            end
            data_read: begin
                cmd.op   = op_read;
                cmd.last = 1'b1;    // single byte, host nacks
            end
            default: cmd.op = op_stop;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= idle;
            cmd_valid <= 1'b0;
            ack       <= 1'b0;
            err       <= 1'b0;
            rd_q      <= 1'b0;
        end else begin
            state     <= state_nxt;
            // new command on every entry into a bus state
            cmd_valid <= (state_nxt != state) && (state_nxt != ackn) &&
                         (state_nxt != idle);
            ack       <= (state_nxt == ackn);
            if (start_req) begin
                rd_q <= ~wr;    // wr wins
                err  <= 1'b0;
            end else if (nack_hit) begin
                err <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_req) begin
            addr_q  <= addr;
            wdata_q <= wdata;
        end
        if (state == data_read && done) begin
            rdata <= rsp.data;
        end
    end

endmodule

// File: source/eeprom_top.sv
`timescale 1ns/1ps

module eeprom_top import i2c_pkg::*, eeprom_pkg::*; (
    input  logic         clk,
    input  logic         arst_n,
    input  logic         wr,
    input  logic         rd,
    input  eeprom_addr_t addr,
    input  eeprom_data_t wdata,
    output eeprom_data_t rdata,
    output logic         ack,
    output logic         err,
    output logic         scl,
    inout  wire          sda
);

    logic     cmd_valid;
    i2c_cmd_t cmd;
    logic     done;
    i2c_rsp_t rsp;
    logic     sda_low;
    logic     sda_in;

    eeprom_wr u_wr (
        .clk       (clk),
        .arst_n    (arst_n),
        .wr        (wr),
        .rd        (rd),
        .addr      (addr),
        .wdata     (wdata),
        .rdata     (rdata),
        .ack       (ack),
        .err       (err),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .done      (done),
        .rsp       (rsp)
    );

    i2c_byte_engine u_engine (
        .clk       (clk),
        .arst_n    (arst_n),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .done      (done),
        .rsp       (rsp),
        .scl       (scl),
        .sda_low   (sda_low),
        .sda_in    (sda_in)
    );

    // open drain, pullup sits on the board
    assign sda    = sda_low ? 1'b0 : 1'bz,
           sda_in = sda;

endmodule

// File: dv/i2c_eeprom_model.sv
`timescale 1ns/1ps

module i2c_eeprom_model import eeprom_pkg::*; (
    input  logic scl,
    inout  wire  sda,
    input  logic wp
);

    eeprom_data_t mem [MEM_DEPTH];
    logic         sda_drv = 1'b0;
    logic         listening = 1'b0;   // inside a frame, not yet nacked
    logic         rd_mode = 1'b0;
    logic         rd_next = 1'b0;
    logic         wpend = 1'b0;
    int           nbits = 0;          // scl rises since start or last ack
    int           byte_idx = 0;
    logic [2:0]   blk;
    logic [7:0]   shreg;
    eeprom_addr_t ptr;
    eeprom_data_t wbuf;

    assign sda = sda_drv ? 1'b0 : 1'bz;

    initial begin
        foreach (mem[i]) mem[i] = 8'hff;    // erased part
    end

    // start and stop are sda edges while scl is high
    always @(sda) begin
        #0.1;
        if (scl === 1'b1 && sda === 1'b0) begin
            listening = 1'b1;
            rd_mode   = 1'b0;
            rd_next   = 1'b0;
            wpend     = 1'b0;
            nbits     = 0;
            byte_idx  = 0;
        end else if (scl === 1'b1 && sda === 1'b1) begin
            if (wpend) begin
                mem[ptr] = wbuf;    // write cycle at stop
            end
            wpend     = 1'b0;
            listening = 1'b0;
            sda_drv   = 1'b0;
        end
    end

    always @(posedge scl) begin
        if (listening) begin
            if (!rd_mode && nbits < 8) begin
                shreg = {shreg[6:0], sda};
            end
            nbits = nbits + 1;
        end
    end

    always @(negedge scl) begin
        if (listening) begin
            if (rd_mode) begin
                if (nbits >= 1 && nbits <= 7) begin
                    sda_drv = ~shreg[7 - nbits];
                end else if (nbits == 8) begin
                    sda_drv = 1'b0;     // host drives the ack bit
                end else if (nbits == 9) begin
                    listening = 1'b0;   // single byte read only
                end
            end else if (nbits == 8) begin
                case (byte_idx)
                    0: begin
                        sda_drv = (shreg[7:4] == DEV_CODE);
                        blk     = shreg[3:1];
                        rd_next = shreg[0];
                    end
                    1: begin
                        sda_drv = 1'b1;
                        ptr     = {blk, shreg};
                    end
                    2: begin
                        sda_drv = ~wp;
                        wbuf    = shreg;
                        wpend   = ~wp;
                    end
                    default: sda_drv = 1'b0;    // no page writes
                endcase
                byte_idx  = byte_idx + 1;
                listening = sda_drv;
            end else if (nbits == 9) begin
                sda_drv = 1'b0;
                nbits   = 0;
                if (rd_next) begin
                    // first data bit right after the control byte ack
                    rd_mode = 1'b1;
                    shreg   = mem[{blk, ptr[7:0]}];
                    sda_drv = ~shreg[7];
                end
            end
        end
    end

endmodule

// File: dv/tb_eeprom_top.sv
`timescale 1ns/1ps

module tb_eeprom_top import eeprom_pkg::*; ();

    localparam int N_RAND  = 64;
    localparam int N_WP    = 4;
    localparam int N_TRANS = 2 * N_RAND + 2 * N_WP + 3;
    localparam int TIMEOUT = 200 * N_TRANS;

    logic         clk = 1'b0;
    logic         arst_n;
    logic         wr;
    logic         rd;
    eeprom_addr_t addr;
    eeprom_data_t wdata;
    eeprom_data_t rdata;
    logic         ack;
    logic         err;
    logic         scl;
    logic         wp;
    wire          sda;

    eeprom_data_t ref_mem [MEM_DEPTH];
    eeprom_addr_t written [$];
    logic [15:0]  lfsr = 16'd53;
    int           cycles = 0;
    int           n_sent = 0;
    int           n_acks = 0;

    pullup (sda);

    eeprom_top DUT (
        .clk(clk), .arst_n(arst_n), .wr(wr), .rd(rd), .addr(addr), .wdata(wdata),
        .rdata(rdata), .ack(ack), .err(err), .scl(scl), .sda(sda)
    );

    i2c_eeprom_model u_mem (.scl(scl), .sda(sda), .wp(wp));

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("timeout, the DUT did not finish within %0d cycles", TIMEOUT);
            $display("** FAIL **");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    always @(negedge clk) begin
        if (arst_n === 1'b1 && ack === 1'b1) begin
            n_acks <= n_acks + 1;
        end
    end

    function automatic logic [15:0] galois_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = galois_step(lfsr);
        end
        return v;
    endfunction

    task automatic check_data(input string name, input eeprom_data_t exp,
                              input eeprom_data_t act);
        if (act !== exp) begin
            $display("Fail %s: expected %02h, actual %02h", name, exp, act);
            $display("** FAIL **");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic check_err(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Fail %s: expected %b, actual %b", name, exp, act);
            $display("** FAIL **");
            $fatal(1, "flag mismatch");
        end
    endtask

    task automatic strobe(input logic is_wr, input eeprom_addr_t a, input eeprom_data_t d);
        @(posedge clk);
        #1;
        wr    = is_wr;
        rd    = ~is_wr;
        addr  = a;
        wdata = d;
        @(posedge clk);
        #1;
        wr = 1'b0;
        rd = 1'b0;
    endtask

    // rdata and err are valid in the ack cycle
    task automatic wait_ack(output eeprom_data_t data, output logic e);
        @(negedge clk);
        while (ack !== 1'b1) @(negedge clk);
        data = rdata;
        e    = err;
        n_sent++;
    endtask

    task automatic finish_write(input eeprom_addr_t a, input eeprom_data_t d,
                                input logic exp_err, input string name);
        eeprom_data_t got;
        logic         e;
        wait_ack(got, e);
        check_err(name, exp_err, e);
        if (!exp_err) begin
            ref_mem[a] = d;
        end
    endtask

    task automatic finish_read(input eeprom_addr_t a, input string name);
        eeprom_data_t got;
        logic         e;
        wait_ack(got, e);
        check_err(name, 1'b0, e);
        check_data(name, ref_mem[a], got);
    endtask

    initial begin
        eeprom_addr_t a;
        eeprom_addr_t b;
        eeprom_data_t d;
        arst_n = 1'b0;
        wr     = 1'b0;
        rd     = 1'b0;
        addr   = '0;
        wdata  = '0;
        wp     = 1'b0;
        foreach (ref_mem[i]) ref_mem[i] = 8'hff;
        repeat (4) @(posedge clk);
        #1;
        arst_n = 1'b1;

        repeat (10) begin
            @(negedge clk);
            check_err("idle scl", 1'b1, scl);
            check_err("idle sda", 1'b1, sda);
            check_err("idle ack", 1'b0, ack);
        end

        for (int i = 0; i < N_RAND; i++) begin
            a = eeprom_addr_t'(rand_bits(11));
            d = eeprom_data_t'(rand_bits(8));
            written.push_back(a);
            strobe(1'b1, a, d);
            finish_write(a, d, 1'b0, $sformatf("write %0d", i));
        end

        // half from the written set, half fresh
        for (int i = 0; i < N_RAND; i++) begin
            if (rand_bits(1) == 1) begin
                a = written[rand_bits(6) % written.size()];
            end else begin
                a = eeprom_addr_t'(rand_bits(11));
            end
            strobe(1'b0, a, '0);
            finish_read(a, $sformatf("read %0d", i));
        end

        @(posedge clk);
        #1;
        wp = 1'b1;
        for (int i = 0; i < N_WP; i++) begin
            a = written[i * 16];
            d = ~ref_mem[a];
            strobe(1'b1, a, d);
            finish_write(a, d, 1'b1, $sformatf("protected write %0d", i));
            strobe(1'b0, a, '0);
            finish_read(a, $sformatf("protected read %0d", i));
        end
        @(posedge clk);
        #1;
        wp = 1'b0;

        // strobes in the middle of a transaction
        a = eeprom_addr_t'(rand_bits(11));
        b = a ^ 11'h555;
        d = eeprom_data_t'(rand_bits(8));
        strobe(1'b1, a, d);
        repeat (8) @(posedge clk);
        strobe(1'b1, b, ~ref_mem[b]);
        finish_write(a, d, 1'b0, "busy write");
        strobe(1'b0, a, '0);
        repeat (8) @(posedge clk);
        strobe(1'b0, b, '0);
        finish_read(a, "busy read");
        strobe(1'b0, b, '0);
        finish_read(b, "intruder address");
        repeat (120) @(posedge clk);

        if (n_acks != n_sent) begin
            $display("Fail ack count: expected %0d, actual %0d", n_sent, n_acks);
            $display("** FAIL **");
            $fatal(1, "wrong number of acks");
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

// File: build.f
source/i2c_pkg.sv
source/eeprom_pkg.sv
source/i2c_byte_engine.sv
source/eeprom_wr.sv
source/eeprom_top.sv
dv/i2c_eeprom_model.sv
dv/tb_eeprom_top.sv
